// ==== flist.f ====
+incdir+verilog
verilog/vlsu_nan_pkg.sv
verilog/vlsu_nan_if.sv
verilog/vlsu_nan_decode.sv
verilog/vlsu_nan_classify.sv
verilog/vlsu_nan_result.sv
verilog/vlsu_nan_checker.sv
dv/vlsu_nan_chk.sv
dv/vlsu_nan_tb.sv

// ==== Bender.yml ====
package:
  name: vlsu_nan_checker

sources:
  # Synthesizable pipeline
  - include_dirs:
      - verilog
    files:
      - verilog/vlsu_nan_pkg.sv
      - verilog/vlsu_nan_if.sv
      - verilog/vlsu_nan_decode.sv
      - verilog/vlsu_nan_classify.sv
      - verilog/vlsu_nan_result.sv
      - verilog/vlsu_nan_checker.sv

  # Simulation only
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/vlsu_nan_chk.sv
      - dv/vlsu_nan_tb.sv

// ==== dv/vlsu_nan_tb.sv ====
`timescale 1ns/1ps

`include "vlsu_nan_macros.svh"

module vlsu_nan_tb;

  localparam int CLK_PERIOD = 8;
  localparam int N_RANDOM   = 40;
  localparam int LATENCY    = 3;

  typedef struct {
    vlsu_nan_pkg::lane_data_t  data;
    vlsu_nan_pkg::lane_strb_t  strb;
    vlsu_nan_pkg::elem_width_e mew;
    logic                      exp_nan;
  } vec_t;

  logic                      clk;
  logic                      reset;
  logic                      in_valid;
  vlsu_nan_pkg::lane_data_t  lane_data;
  vlsu_nan_pkg::lane_strb_t  lane_strb;
  vlsu_nan_pkg::elem_width_e lane_mew;
  logic                      out_valid;
  logic                      has_nan;

  vec_t vec_q[$];
  int   stamp_q[$];
  int   seed;
  int   cycle_cnt;
  int   out_cnt;
  int   err_cnt;
  int   chk_cnt;
  bit   table_ready;

  vlsu_nan_checker dut_i (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .lane_data (lane_data),
    .lane_strb (lane_strb),
    .lane_mew  (lane_mew),
    .out_valid (out_valid),
    .has_nan   (has_nan)
  );

  bind vlsu_nan_checker vlsu_nan_chk chk_i (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .has_nan   (has_nan)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  function automatic logic ref_has_nan(input vlsu_nan_pkg::lane_data_t  data,
                                       input vlsu_nan_pkg::lane_strb_t  strb,
                                       input vlsu_nan_pkg::elem_width_e mew);
    int          nbytes;
    logic [63:0] e;
    logic        found;
    nbytes = 1 << mew;
    found  = 1'b0;
    // Walk elements by their lowest byte
    for (int b = 0; b < `VLSU_NAN_STRB_W; b += nbytes) begin
      e = 64'(data >> (b * 8));
      if (strb[b]) begin
        case (mew)
          vlsu_nan_pkg::ELEM_BYTE: found = found | (e[6:0] == 7'h7f);
          vlsu_nan_pkg::ELEM_HALF: found = found | (e[14:10] == 5'h1f && e[9:0] != 0)
                                                 | (e[14:7] == 8'hff && e[6:0] != 0);
          vlsu_nan_pkg::ELEM_WORD: found = found | (e[30:23] == 8'hff && e[22:0] != 0);
          default:                 found = found | (e[62:52] == 11'h7ff && e[51:0] != 0);
        endcase
      end
    end
    return found;
  endfunction

  // --------------------------------------------------
  // Stimulus table
  // --------------------------------------------------
  task automatic add_vec(input vlsu_nan_pkg::lane_data_t  data,
                         input vlsu_nan_pkg::lane_strb_t  strb,
                         input vlsu_nan_pkg::elem_width_e mew,
                         input logic                      exp_nan);
    vec_t v;
    v.data    = data;
    v.strb    = strb;
    v.mew     = mew;
    v.exp_nan = exp_nan;
    vec_q.push_back(v);
  endtask

  task automatic add_random_vecs(input int n);
    vlsu_nan_pkg::lane_data_t  data;
    vlsu_nan_pkg::lane_data_t  mask;
    vlsu_nan_pkg::lane_strb_t  strb;
    vlsu_nan_pkg::elem_width_e mew;
    logic [31:0]               sel;
    int                        slot;
    for (int i = 0; i < n; i++) begin
      data = {$random(seed), $random(seed), $random(seed), $random(seed)};
      strb = $random(seed);
      mew  = vlsu_nan_pkg::elem_width_e'($random(seed) & 3);
      sel  = $random(seed);
      // Half the time plant an all-ones exponent so NaNs show up
      if (sel[0]) begin
        case (mew)
          vlsu_nan_pkg::ELEM_BYTE: mask = 128'h7f;
          vlsu_nan_pkg::ELEM_HALF: mask = 128'h7c00;
          vlsu_nan_pkg::ELEM_WORD: mask = 128'h7f80_0000;
          default:                 mask = 128'h7ff0_0000_0000_0000;
        endcase
        slot = int'(sel[7:4]) % (16 >> mew);
        data = data | (mask << (slot * (8 << mew)));
      end
      add_vec(data, strb, mew, ref_has_nan(data, strb, mew));
    end
  endtask

  task automatic build_table();
    // OFP8 E4M3 bytes
    add_vec(128'h7f, 16'h0001, vlsu_nan_pkg::ELEM_BYTE, 1'b1);
    add_vec(128'hff_0000_0000_00, 16'h0020, vlsu_nan_pkg::ELEM_BYTE, 1'b1);
    add_vec(128'h7e, 16'hffff, vlsu_nan_pkg::ELEM_BYTE, 1'b0);
    add_vec(128'h7f, 16'hfffe, vlsu_nan_pkg::ELEM_BYTE, 1'b0);
    // Halves, BF16 or FP16
    add_vec(128'h7fc1, 16'h0001, vlsu_nan_pkg::ELEM_HALF, 1'b1);
    add_vec(128'h7e00, 16'h0001, vlsu_nan_pkg::ELEM_HALF, 1'b1);
    add_vec(128'h7c00, 16'hffff, vlsu_nan_pkg::ELEM_HALF, 1'b0);
    // BF16 infinity is also an FP16 NaN
    add_vec(128'h7f80, 16'h0001, vlsu_nan_pkg::ELEM_HALF, 1'b1);
    add_vec(128'h7e00_0000, 16'h0008, vlsu_nan_pkg::ELEM_HALF, 1'b0);
    add_vec(128'h7e00_0000, 16'h0004, vlsu_nan_pkg::ELEM_HALF, 1'b1);
    // FP32 words
    add_vec(128'h7fc0_0000, 16'h0001, vlsu_nan_pkg::ELEM_WORD, 1'b1);
    add_vec(128'h7f80_0001, 16'h0001, vlsu_nan_pkg::ELEM_WORD, 1'b1);
    add_vec(128'h7f80_0000, 16'hffff, vlsu_nan_pkg::ELEM_WORD, 1'b0);
    add_vec(128'h0, 16'hffff, vlsu_nan_pkg::ELEM_WORD, 1'b0);
    add_vec(128'h7fc0_0000_0000_0000_0000_0000, 16'h0100, vlsu_nan_pkg::ELEM_WORD, 1'b1);
    add_vec(128'h7fc0_0000_0000_0000_0000_0000, 16'hfeff, vlsu_nan_pkg::ELEM_WORD, 1'b0);
    // FP64 doublewords
    add_vec(128'h7ff8_0000_0000_0000, 16'h0001, vlsu_nan_pkg::ELEM_DWRD, 1'b1);
    add_vec(128'h7ff0_0000_0000_0001, 16'h0001, vlsu_nan_pkg::ELEM_DWRD, 1'b1);
    add_vec(128'h7ff0_0000_0000_0000, 16'hffff, vlsu_nan_pkg::ELEM_DWRD, 1'b0);
    add_vec(128'h0, 16'hffff, vlsu_nan_pkg::ELEM_DWRD, 1'b0);
    add_vec({64'h7ff8_0000_0000_0000, 64'h0}, 16'h0100, vlsu_nan_pkg::ELEM_DWRD, 1'b1);
    add_vec({64'h7ff8_0000_0000_0000, 64'h0}, 16'hfeff, vlsu_nan_pkg::ELEM_DWRD, 1'b0);
    // Same negative FP64 infinity under each width
    add_vec(128'hfff0_0000_0000_0000, 16'hffff, vlsu_nan_pkg::ELEM_BYTE, 1'b1);
    add_vec(128'hfff0_0000_0000_0000, 16'hffff, vlsu_nan_pkg::ELEM_DWRD, 1'b0);
    add_vec(128'hfff0_0000_0000_0000, 16'hffff, vlsu_nan_pkg::ELEM_WORD, 1'b1);
    add_vec(128'hfff0_0000_0000_0000, 16'hffff, vlsu_nan_pkg::ELEM_HALF, 1'b1);
    add_random_vecs(N_RANDOM);
  endtask

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------
  task automatic check_has_nan(input int idx, input logic exp, input logic got);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Mismatch at %0t: has_nan entry %0d expected %b got %b", $time, idx, exp, got);
    end
  endtask

  task automatic check_latency(input int idx, input int exp, input int got);
    chk_cnt++;
    if (got != exp) begin
      err_cnt++;
      $display("Mismatch at %0t: out_valid latency entry %0d expected %0d got %0d",
               $time, idx, exp, got);
    end
  endtask

  // Results come back in order, entry index is the result count
  always @(posedge clk) begin : monitor
    int stamp;
    cycle_cnt = cycle_cnt + 1;
    if (!reset) begin
      if (in_valid) begin
        stamp_q.push_back(cycle_cnt);
      end
      if (!out_valid && has_nan) begin
        err_cnt++;
        $display("has_nan is high at %0t while out_valid is low", $time);
      end
      if (out_valid) begin
        if (stamp_q.size() == 0) begin
          err_cnt++;
          $display("out_valid is high at %0t with no sample in flight", $time);
        end else begin
          stamp = stamp_q.pop_front();
          check_latency(out_cnt, LATENCY, cycle_cnt - stamp);
          if (out_cnt < vec_q.size()) begin
            check_has_nan(out_cnt, vec_q[out_cnt].exp_nan, has_nan);
          end
          out_cnt++;
        end
      end
    end
  end

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    reset       = 1'b1;
    in_valid    = 1'b0;
    lane_data   = '0;
    lane_strb   = '0;
    lane_mew    = vlsu_nan_pkg::ELEM_BYTE;
    seed        = 32'hd4098b14;
    cycle_cnt   = 0;
    out_cnt     = 0;
    err_cnt     = 0;
    chk_cnt     = 0;
    build_table();
    table_ready = 1'b1;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    // Back to back, one entry per cycle
    foreach (vec_q[i]) begin
      @(posedge clk);
      in_valid  <= 1'b1;
      lane_data <= vec_q[i].data;
      lane_strb <= vec_q[i].strb;
      lane_mew  <= vec_q[i].mew;
    end
    @(posedge clk);
    in_valid <= 1'b0;
    for (int k = 0; k < 10 && out_cnt < vec_q.size(); k++) begin
      @(negedge clk);
    end
    if (out_cnt != vec_q.size()) begin
      err_cnt++;
      $display("Only %0d of %0d samples came back with out_valid", out_cnt, vec_q.size());
    end
    err_cnt = err_cnt + dut_i.chk_i.fail_cnt;
    $display("Checks run: %0d, errors: %0d, assertion failures: %0d",
             chk_cnt, err_cnt, dut_i.chk_i.fail_cnt);
    if (err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Table length plus margin for reset and pipeline drain
  initial begin : watchdog
    wait (table_ready);
    #((vec_q.size() + 20) * CLK_PERIOD);
    $display("Timeout, the run did not finish within %0d cycles", vec_q.size() + 20);
    $display("tests failed");
    $finish;
  end

endmodule

// ==== dv/vlsu_nan_chk.sv ====
`timescale 1ns/1ps

module vlsu_nan_chk (
  input logic clk,
  input logic reset,
  input logic in_valid,
  input logic out_valid,
  input logic has_nan
);

  // Assertion failures so far
  int fail_cnt = 0;

  // --------------------------------------------------
  // Pipeline latency
  // --------------------------------------------------

  // Three registers between in_valid and out_valid, no reset in between
  a_latency: assert property (@(posedge clk) disable iff (reset)
    (!$past(reset, 1) && !$past(reset, 2) && !$past(reset, 3))
      |-> (out_valid == $past(in_valid, 3)))
  else begin
    fail_cnt++;
    $error("out_valid is not in_valid delayed by three cycles");
  end

  // --------------------------------------------------
  // Output qualification
  // --------------------------------------------------
  a_nan_qual: assert property (@(posedge clk) disable iff (reset)
    !out_valid |-> !has_nan)
  else begin
    fail_cnt++;
    $error("has_nan high without out_valid");
  end

  // First cycle out of reset
  a_reset_out: assert property (@(posedge clk)
    $fell(reset) |-> (!out_valid && !has_nan))
  else begin
    fail_cnt++;
    $error("outputs not cleared by reset");
  end

endmodule

// ==== verilog/vlsu_nan_checker.sv ====
`timescale 1ns/1ps

module vlsu_nan_checker (
  input  logic                      clk,
  input  logic                      reset,

  // Load lane, one sample per cycle with in_valid
  input  logic                      in_valid,
  input  vlsu_nan_pkg::lane_data_t  lane_data,
  input  vlsu_nan_pkg::lane_strb_t  lane_strb,
  input  vlsu_nan_pkg::elem_width_e lane_mew,

  // Result, three cycles after the sample
  output logic                      out_valid,
  output logic                      has_nan
);

  // --------------------------------------------------
  // Stage links
  // --------------------------------------------------
  lane_elem_if elem_if ();
  nan_flag_if  flag_if ();

  // --------------------------------------------------
  // Pipeline
  // --------------------------------------------------

  // Stage 1, register lane and expand strobes
  vlsu_nan_decode decode_i (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .lane_data (lane_data),
    .lane_strb (lane_strb),
    .lane_mew  (lane_mew),
    .elem      (elem_if.decode_mp)
  );

  // Stage 2, per-element NaN flags for every format
  vlsu_nan_classify classify_i (
    .clk   (clk),
    .reset (reset),
    .elem  (elem_if.classify_in_mp),
    .flags (flag_if.classify_out_mp)
  );

  // Stage 3, mask, reduce and pick by width
  vlsu_nan_result result_i (
    .clk       (clk),
    .reset     (reset),
    .flags     (flag_if.result_mp),
    .out_valid (out_valid),
    .has_nan   (has_nan)
  );

endmodule

// ==== verilog/vlsu_nan_result.sv ====
`timescale 1ns/1ps

module vlsu_nan_result (
  input  logic          clk,
  input  logic          reset,
  nan_flag_if.result_mp flags,
  output logic          out_valid,
  output logic          has_nan
);

  logic byte_any;
  logic half_any;
  logic word_any;
  logic dwrd_any;
  logic sel_nan;

  // --------------------------------------------------
  // Masked reduction per width
  // --------------------------------------------------

  // Inactive elements never raise the flag
  assign byte_any = |(flags.byte_nan & flags.byte_vld);
  assign half_any = |(flags.half_nan & flags.half_vld);
  assign word_any = |(flags.word_nan & flags.word_vld);
  assign dwrd_any = |(flags.dwrd_nan & flags.dwrd_vld);

  // --------------------------------------------------
  // Width select
  // --------------------------------------------------
  always_comb begin
    case (flags.width)
      vlsu_nan_pkg::ELEM_BYTE: begin
        sel_nan = byte_any;
      end
      vlsu_nan_pkg::ELEM_HALF: begin
        sel_nan = half_any;
      end
      vlsu_nan_pkg::ELEM_WORD: begin
        sel_nan = word_any;
      end
      vlsu_nan_pkg::ELEM_DWRD: begin
        sel_nan = dwrd_any;
      end
      default: begin
        sel_nan = 1'b0;
      end
    endcase
  end

  // --------------------------------------------------
  // Output register
  // --------------------------------------------------

  // has_nan stays low in any cycle without a result
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
      has_nan   <= 1'b0;
    end else begin
      out_valid <= flags.vld;
      has_nan   <= flags.vld & sel_nan;
    end
  end

endmodule

// ==== verilog/vlsu_nan_classify.sv ====
`timescale 1ns/1ps

`include "vlsu_nan_macros.svh"

module vlsu_nan_classify (
  input  logic                clk,
  input  logic                reset,
  lane_elem_if.classify_in_mp elem,
  nan_flag_if.classify_out_mp flags
);

  localparam int HALF_W = 1 + `VLSU_NAN_FP16_EXP + `VLSU_NAN_FP16_MAN;
  localparam int WORD_W = 1 + `VLSU_NAN_FP32_EXP + `VLSU_NAN_FP32_MAN;
  localparam int DWRD_W = 1 + `VLSU_NAN_FP64_EXP + `VLSU_NAN_FP64_MAN;

  vlsu_nan_pkg::byte_flags_t byte_nan_c;
  vlsu_nan_pkg::half_flags_t half_nan_c;
  vlsu_nan_pkg::word_flags_t word_nan_c;
  vlsu_nan_pkg::dwrd_flags_t dwrd_nan_c;

  // --------------------------------------------------
  // OFP8 E4M3, 16 bytes
  // --------------------------------------------------
  for (genvar i = 0; i < `VLSU_NAN_N_BYTE; i++) begin : g_byte
    assign byte_nan_c[i] = &elem.data[i*8 +: `VLSU_NAN_OFP8_MASK_W];
  end

  // --------------------------------------------------
  // BF16 or FP16, 8 halves
  // --------------------------------------------------
  for (genvar i = 0; i < `VLSU_NAN_N_HALF; i++) begin : g_half
    logic [HALF_W-1:0] half_w;
    logic              fp16_nan;
    logic              bf16_nan;

    assign half_w = elem.data[i*HALF_W +: HALF_W];

    // Exponent all ones, mantissa nonzero
    assign fp16_nan = (&half_w[`VLSU_NAN_FP16_MAN +: `VLSU_NAN_FP16_EXP])
                    & (|half_w[`VLSU_NAN_FP16_MAN-1:0]);
    assign bf16_nan = (&half_w[`VLSU_NAN_BF16_MAN +: `VLSU_NAN_BF16_EXP])
                    & (|half_w[`VLSU_NAN_BF16_MAN-1:0]);

    // Either reading of the half counts
    assign half_nan_c[i] = fp16_nan | bf16_nan;
  end

  // --------------------------------------------------
  // FP32 words and FP64 doublewords
  // --------------------------------------------------
  for (genvar i = 0; i < `VLSU_NAN_N_WORD; i++) begin : g_word
    logic [WORD_W-1:0] word_w;

    assign word_w        = elem.data[i*WORD_W +: WORD_W];
    assign word_nan_c[i] = (&word_w[`VLSU_NAN_FP32_MAN +: `VLSU_NAN_FP32_EXP])
                         & (|word_w[`VLSU_NAN_FP32_MAN-1:0]);
  end

  for (genvar i = 0; i < `VLSU_NAN_N_DWRD; i++) begin : g_dwrd
    logic [DWRD_W-1:0] dwrd_w;

    assign dwrd_w        = elem.data[i*DWRD_W +: DWRD_W];
    assign dwrd_nan_c[i] = (&dwrd_w[`VLSU_NAN_FP64_MAN +: `VLSU_NAN_FP64_EXP])
                         & (|dwrd_w[`VLSU_NAN_FP64_MAN-1:0]);
  end

  // --------------------------------------------------
  // Stage register
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      flags.vld <= 1'b0;
    end else begin
      flags.vld <= elem.vld;
    end
  end

  always_ff @(posedge clk) begin
    flags.width    <= elem.width;
    flags.byte_vld <= elem.byte_vld;
    flags.half_vld <= elem.half_vld;
    flags.word_vld <= elem.word_vld;
    flags.dwrd_vld <= elem.dwrd_vld;
    flags.byte_nan <= byte_nan_c;
    flags.half_nan <= half_nan_c;
    flags.word_nan <= word_nan_c;
    flags.dwrd_nan <= dwrd_nan_c;
  end

endmodule

// ==== verilog/vlsu_nan_decode.sv ====
`timescale 1ns/1ps

`include "vlsu_nan_macros.svh"

module vlsu_nan_decode (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      in_valid,
  input  vlsu_nan_pkg::lane_data_t  lane_data,
  input  vlsu_nan_pkg::lane_strb_t  lane_strb,
  input  vlsu_nan_pkg::elem_width_e lane_mew,
  lane_elem_if.decode_mp            elem
);

  vlsu_nan_pkg::half_flags_t half_vld_c;
  vlsu_nan_pkg::word_flags_t word_vld_c;
  vlsu_nan_pkg::dwrd_flags_t dwrd_vld_c;

  // --------------------------------------------------
  // Strobe expansion
  // --------------------------------------------------

  // An element counts when the strobe of its lowest byte is set
  for (genvar i = 0; i < `VLSU_NAN_N_HALF; i++) begin : g_half_vld
    assign half_vld_c[i] = lane_strb[2*i];
  end

  for (genvar i = 0; i < `VLSU_NAN_N_WORD; i++) begin : g_word_vld
    assign word_vld_c[i] = lane_strb[4*i];
  end

  for (genvar i = 0; i < `VLSU_NAN_N_DWRD; i++) begin : g_dwrd_vld
    assign dwrd_vld_c[i] = lane_strb[8*i];
  end

  // --------------------------------------------------
  // Input register
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      elem.vld <= 1'b0;
    end else begin
      elem.vld <= in_valid;
    end
  end

  // Payload follows the valid bit, no reset needed
  always_ff @(posedge clk) begin
    elem.data     <= lane_data;
    elem.width    <= lane_mew;
    elem.byte_vld <= lane_strb;
    elem.half_vld <= half_vld_c;
    elem.word_vld <= word_vld_c;
    elem.dwrd_vld <= dwrd_vld_c;
  end

endmodule

// ==== verilog/vlsu_nan_if.sv ====
`timescale 1ns/1ps

// --------------------------------------------------
// Decode to classify
// --------------------------------------------------
interface lane_elem_if;

  logic                      vld;
  vlsu_nan_pkg::lane_data_t  data;
  vlsu_nan_pkg::elem_width_e width;

  // Element valid, taken from the strobe of each element's lowest byte
  vlsu_nan_pkg::byte_flags_t byte_vld;
  vlsu_nan_pkg::half_flags_t half_vld;
  vlsu_nan_pkg::word_flags_t word_vld;
  vlsu_nan_pkg::dwrd_flags_t dwrd_vld;

  modport decode_mp (
    output vld, data, width,
    output byte_vld, half_vld, word_vld, dwrd_vld
  );

  modport classify_in_mp (
    input vld, data, width,
    input byte_vld, half_vld, word_vld, dwrd_vld
  );

endinterface

// --------------------------------------------------
// Classify to result
// --------------------------------------------------
interface nan_flag_if;

  logic                      vld;
  vlsu_nan_pkg::elem_width_e width;

  // Masks carried along from decode
  vlsu_nan_pkg::byte_flags_t byte_vld;
  vlsu_nan_pkg::half_flags_t half_vld;
  vlsu_nan_pkg::word_flags_t word_vld;
  vlsu_nan_pkg::dwrd_flags_t dwrd_vld;

  // Raw NaN flags, not yet masked
  vlsu_nan_pkg::byte_flags_t byte_nan;
  vlsu_nan_pkg::half_flags_t half_nan;
  vlsu_nan_pkg::word_flags_t word_nan;
  vlsu_nan_pkg::dwrd_flags_t dwrd_nan;

  modport classify_out_mp (
    output vld, width,
    output byte_vld, half_vld, word_vld, dwrd_vld,
    output byte_nan, half_nan, word_nan, dwrd_nan
  );

  modport result_mp (
    input vld, width,
    input byte_vld, half_vld, word_vld, dwrd_vld,
    input byte_nan, half_nan, word_nan, dwrd_nan
  );

endinterface

// ==== verilog/vlsu_nan_pkg.sv ====
`include "vlsu_nan_macros.svh"

package vlsu_nan_pkg;

  // --------------------------------------------------
  // Lane payload
  // --------------------------------------------------

  // Loaded lane data, element 0 in the low bits
  typedef logic [`VLSU_NAN_LANE_W-1:0] lane_data_t;

  // One strobe bit per byte of the lane
  typedef logic [`VLSU_NAN_STRB_W-1:0] lane_strb_t;

  // --------------------------------------------------
  // Memory element width
  // --------------------------------------------------

  // Encoding follows the mew field of the load
  typedef enum logic [1:0] {
    ELEM_BYTE = 2'd0,
    ELEM_HALF = 2'd1,
    ELEM_WORD = 2'd2,
    ELEM_DWRD = 2'd3
  } elem_width_e;

  // --------------------------------------------------
  // Per-element vectors
  // --------------------------------------------------

  // Used both as NaN flags and as element valid masks
  typedef logic [`VLSU_NAN_N_BYTE-1:0] byte_flags_t;
  typedef logic [`VLSU_NAN_N_HALF-1:0] half_flags_t;
  typedef logic [`VLSU_NAN_N_WORD-1:0] word_flags_t;
  typedef logic [`VLSU_NAN_N_DWRD-1:0] dwrd_flags_t;

endpackage

// ==== verilog/vlsu_nan_macros.svh ====
`ifndef VLSU_NAN_MACROS_SVH
`define VLSU_NAN_MACROS_SVH

// --------------------------------------------------
// Lane geometry
// --------------------------------------------------
`define VLSU_NAN_LANE_W       128
`define VLSU_NAN_STRB_W       16

// Element counts per width code
`define VLSU_NAN_N_BYTE       16
`define VLSU_NAN_N_HALF       8
`define VLSU_NAN_N_WORD       4
`define VLSU_NAN_N_DWRD       2

// --------------------------------------------------
// Float field sizes
// --------------------------------------------------
`define VLSU_NAN_FP16_EXP     5
`define VLSU_NAN_FP16_MAN     10
`define VLSU_NAN_BF16_EXP     8
`define VLSU_NAN_BF16_MAN     7
`define VLSU_NAN_FP32_EXP     8
`define VLSU_NAN_FP32_MAN     23
`define VLSU_NAN_FP64_EXP     11
`define VLSU_NAN_FP64_MAN     52

// E4M3 NaN is S.1111.111, sign ignored
`define VLSU_NAN_OFP8_MASK_W  7

`endif
